/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int lane_w     = 8;
    localparam int lanes      = 16;
    localparam int glb_width  = lane_w * lanes;
    localparam int glb_words  = 64;
    localparam int glb_addr_w = $clog2(glb_words);

    localparam int isa_width  = 32;
    localparam int isa_words  = 64;
    localparam int isa_addr_w = $clog2(isa_words);

    // Opcode sits in bits 31:28 of every instruction
    typedef enum logic [3:0] {
        op_end   = 4'h0,  // An all-zero word ends the program
        op_set   = 4'h1,
        op_load  = 4'h2,
        op_store = 4'h3
    } op_e;

    // LOAD and STORE carry a buffer address in the low bits
    typedef struct packed {
        op_e                                   op;
        logic [isa_width-4-glb_addr_w-1:0]     rsvd;
        logic [glb_addr_w-1:0]                 addr;
    } mem_fmt_t;

    // SET carries one byte that is copied to every lane
    typedef struct packed {
        op_e                                   op;
        logic [isa_width-4-lane_w-1:0]         rsvd;
        logic [lane_w-1:0]                     imm;
    } imm_fmt_t;

    typedef union packed {
        mem_fmt_t mem_f;
        imm_fmt_t imm_f;
    } instr_u;

    typedef struct packed {
        logic                  isa_we;  // Instruction write with its data in wdata[31:0]
        logic                  glb_we;
        logic                  glb_re;
        logic [glb_addr_w-1:0] addr;    // Shared by both banks
        logic [glb_width-1:0]  wdata;
    } host_cmd_t;

    typedef enum logic [1:0] {
        acc_hold = 2'd0,
        acc_set  = 2'd1,
        acc_add  = 2'd2
    } acc_op_e;

endpackage

`default_nettype wire

/* verilog/sram_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_bank #(
    parameter int words = 64,
    parameter int width = 128
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [$clog2(words)-1:0] addr_r,
    input  wire [$clog2(words)-1:0] addr_w,
    input  wire                     read_en,
    input  wire                     write_en,
    input  wire [width-1:0]         data_in,
    output logic [width-1:0]        data_out
);

    logic [width-1:0]         mem [words];
    logic [$clog2(words)-1:0] addr;
    logic [width-1:0]         rd_q;
    logic                     read_en_d;
    logic [width-1:0]         hold_q;

    // One physical port, so the write address wins
    assign addr = write_en ? addr_w : addr_r;

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= data_in;
        end else if (read_en) begin
            rd_q <= mem[addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_en_d <= 1'b0;
        end else begin
            read_en_d <= read_en;  // Marks the cycle in which rd_q is fresh
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= '0;
        end else if (read_en_d) begin
            hold_q <= rd_q;  // Keep the last read until the next one lands
        end
    end

    assign data_out = read_en_d ? rd_q : hold_q;

    // Host and sequencer muxing upstream must never ask for both in one cycle
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(read_en && write_en)
    ) else $error("read_en and write_en high together");

endmodule

`default_nettype wire

/* verilog/vec_acc.sv */
`timescale 1ns/1ns
`default_nettype none

module vec_acc (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire core_pkg::acc_op_e         acc_op,
    input  wire [core_pkg::lane_w-1:0]     imm,
    input  wire [core_pkg::glb_width-1:0]  operand,
    output logic [core_pkg::glb_width-1:0] acc_q
);

    logic [core_pkg::glb_width-1:0] lane_sum;
    logic [core_pkg::glb_width-1:0] lane_fill;

    // Each lane wraps on its own, no carry crosses a lane boundary
    always_comb begin
        for (int i = 0; i < core_pkg::lanes; i++) begin
            lane_sum[i*core_pkg::lane_w +: core_pkg::lane_w] =
                acc_q[i*core_pkg::lane_w +: core_pkg::lane_w] +
                operand[i*core_pkg::lane_w +: core_pkg::lane_w];
        end
    end

    assign lane_fill = {core_pkg::lanes{imm}};  // Broadcast immediate for SET

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else begin
            case (acc_op)
                core_pkg::acc_set: begin
                    acc_q <= lane_fill;
                end
                core_pkg::acc_add: begin
                    acc_q <= lane_sum;
                end
                default: begin
                    acc_q <= acc_q;  // HOLD
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/core_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module core_ctrl (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire core_pkg::host_cmd_t        host,
    input  wire                             start,
    input  wire [core_pkg::isa_width-1:0]   isa_rdata,
    input  wire [core_pkg::glb_width-1:0]   acc_q,
    output logic                            busy,
    output logic                            done,
    output logic                            isa_read_en,
    output logic                            isa_write_en,
    output logic [core_pkg::isa_addr_w-1:0] isa_addr_r,
    output logic [core_pkg::isa_addr_w-1:0] isa_addr_w,
    output logic [core_pkg::isa_width-1:0]  isa_wdata,
    output logic                            glb_read_en,
    output logic                            glb_write_en,
    output logic [core_pkg::glb_addr_w-1:0] glb_addr_r,
    output logic [core_pkg::glb_addr_w-1:0] glb_addr_w,
    output logic [core_pkg::glb_width-1:0]  glb_wdata,
    output core_pkg::acc_op_e               acc_op,
    output logic [core_pkg::lane_w-1:0]     acc_imm
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_exec,
        st_load_wait,
        st_finish
    } state_e;

    state_e                          state;
    state_e                          state_nxt;
    logic [core_pkg::isa_addr_w-1:0] pc;
    core_pkg::instr_u                instr;
    logic                            retire;
    logic                            last_pc;

    assign busy    = (state != st_idle) && (state != st_finish);
    assign done    = (state == st_finish);
    assign last_pc = (pc == core_pkg::isa_words - 1);  // Runaway programs stop here

    // Sequencer
    always_comb begin
        state_nxt = state;
        retire    = 1'b0;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_fetch;
                end
            end
            st_fetch: begin
                state_nxt = st_decode;
            end
            st_decode: begin
                state_nxt = st_exec;
            end
            st_exec: begin
                case (instr.mem_f.op)
                    core_pkg::op_set, core_pkg::op_store: begin
                        retire = 1'b1;
                    end
                    core_pkg::op_load: begin
                        state_nxt = st_load_wait;
                    end
                    default: begin
                        state_nxt = st_finish;  // END, and anything unknown
                    end
                endcase
            end
            st_load_wait: begin
                retire = 1'b1;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
        if (retire) begin
            state_nxt = last_pc ? st_finish : st_fetch;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_idle) begin
                pc <= '0;
            end else if (retire) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Instruction word is valid in DECODE, one cycle after the fetch read
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            instr <= isa_rdata;
        end
    end

    // Bank port select and execute strobes
    always_comb begin
        isa_read_en  = 1'b0;
        isa_write_en = 1'b0;
        isa_addr_r   = pc;
        isa_addr_w   = host.addr;
        isa_wdata    = host.wdata[core_pkg::isa_width-1:0];
        glb_read_en  = 1'b0;
        glb_write_en = 1'b0;
        glb_addr_r   = instr.mem_f.addr;
        glb_addr_w   = instr.mem_f.addr;
        glb_wdata    = acc_q;
        acc_op       = core_pkg::acc_hold;
        acc_imm      = instr.imm_f.imm;
        if (!busy) begin
            isa_write_en = host.isa_we;
            glb_write_en = host.glb_we;
            glb_read_en  = host.glb_re;
            glb_addr_r   = host.addr;
            glb_addr_w   = host.addr;
            glb_wdata    = host.wdata;
        end else begin
            case (state)
                st_fetch: begin
                    isa_read_en = 1'b1;
                end
                st_exec: begin
                    case (instr.mem_f.op)
                        core_pkg::op_set:   acc_op       = core_pkg::acc_set;
                        core_pkg::op_load:  glb_read_en  = 1'b1;
                        core_pkg::op_store: glb_write_en = 1'b1;
                        default:            acc_op       = core_pkg::acc_hold;
                    endcase
                end
                st_load_wait: begin
                    acc_op = core_pkg::acc_add;  // Buffer word is on data_out now
                end
                default: begin
                    acc_op = core_pkg::acc_hold;
                end
            endcase
        end
    end

    a_no_host_write_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> !(host.isa_we || host.glb_we)
    ) else $error("host write while busy");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done && !busy
    ) else $error("done longer than one cycle");

    // Program RAM contents come from the host, so a bad opcode is possible
    a_known_opcode: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == st_exec) |-> instr.mem_f.op inside {core_pkg::op_set, core_pkg::op_load,
                                                       core_pkg::op_store, core_pkg::op_end}
    ) else $error("unknown opcode decoded");

endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire core_pkg::host_cmd_t       host,
    input  wire                            start,
    output logic                           busy,
    output logic                           done,
    output logic [core_pkg::glb_width-1:0] glb_rdata
);

    logic                            isa_read_en;
    logic                            isa_write_en;
    logic [core_pkg::isa_addr_w-1:0] isa_addr_r;
    logic [core_pkg::isa_addr_w-1:0] isa_addr_w;
    logic [core_pkg::isa_width-1:0]  isa_wdata;
    logic [core_pkg::isa_width-1:0]  isa_rdata;
    logic                            glb_read_en;
    logic                            glb_write_en;
    logic [core_pkg::glb_addr_w-1:0] glb_addr_r;
    logic [core_pkg::glb_addr_w-1:0] glb_addr_w;
    logic [core_pkg::glb_width-1:0]  glb_wdata;
    logic [core_pkg::glb_width-1:0]  acc_q;
    core_pkg::acc_op_e               acc_op;
    logic [core_pkg::lane_w-1:0]     acc_imm;

    core_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .host         (host),
        .start        (start),
        .isa_rdata    (isa_rdata),
        .acc_q        (acc_q),
        .busy         (busy),
        .done         (done),
        .isa_read_en  (isa_read_en),
        .isa_write_en (isa_write_en),
        .isa_addr_r   (isa_addr_r),
        .isa_addr_w   (isa_addr_w),
        .isa_wdata    (isa_wdata),
        .glb_read_en  (glb_read_en),
        .glb_write_en (glb_write_en),
        .glb_addr_r   (glb_addr_r),
        .glb_addr_w   (glb_addr_w),
        .glb_wdata    (glb_wdata),
        .acc_op       (acc_op),
        .acc_imm      (acc_imm)
    );

    sram_bank #(
        .words (core_pkg::isa_words),
        .width (core_pkg::isa_width)
    ) u_isa_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr_r   (isa_addr_r),
        .addr_w   (isa_addr_w),
        .read_en  (isa_read_en),
        .write_en (isa_write_en),
        .data_in  (isa_wdata),
        .data_out (isa_rdata)
    );

    // Buffer read data serves both LOAD and host readback
    sram_bank #(
        .words (core_pkg::glb_words),
        .width (core_pkg::glb_width)
    ) u_glb (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr_r   (glb_addr_r),
        .addr_w   (glb_addr_w),
        .read_en  (glb_read_en),
        .write_en (glb_write_en),
        .data_in  (glb_wdata),
        .data_out (glb_rdata)
    );

    vec_acc u_acc (
        .clk     (clk),
        .rst_n   (rst_n),
        .acc_op  (acc_op),
        .imm     (acc_imm),
        .operand (glb_rdata),
        .acc_q   (acc_q)
    );

endmodule

`default_nettype wire

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Host-side mirrors of both banks and the accumulator
logic [core_pkg::glb_width-1:0] exp_glb [core_pkg::glb_words];
logic [core_pkg::isa_width-1:0] exp_isa [core_pkg::isa_words];
logic [core_pkg::glb_width-1:0] exp_acc = '0;

function automatic logic [core_pkg::glb_width-1:0] lane_add(
    input logic [core_pkg::glb_width-1:0] a,
    input logic [core_pkg::glb_width-1:0] b
);
    logic [core_pkg::glb_width-1:0] sum;
    logic [core_pkg::lane_w:0]      wide;
    for (int i = 0; i < core_pkg::lanes; i++) begin
        wide = a[i*core_pkg::lane_w +: core_pkg::lane_w] +
               b[i*core_pkg::lane_w +: core_pkg::lane_w];
        sum[i*core_pkg::lane_w +: core_pkg::lane_w] = wide[core_pkg::lane_w-1:0];  // Drop carry
    end
    return sum;
endfunction

// Runs the stored program on the mirrors until END or the instruction limit
function automatic void run_model();
    logic [core_pkg::isa_width-1:0] word;
    int                             pc;
    logic                           stop;
    pc   = 0;
    stop = 1'b0;
    while (!stop && pc < core_pkg::isa_words) begin
        word = exp_isa[pc];
        case (word[31:28])
            core_pkg::op_set: begin
                exp_acc = {core_pkg::lanes{word[7:0]}};
            end
            core_pkg::op_load: begin
                exp_acc = lane_add(exp_acc, exp_glb[word[5:0]]);
            end
            core_pkg::op_store: begin
                exp_glb[word[5:0]] = exp_acc;
            end
            default: begin
                stop = 1'b1;  // END and anything unknown
            end
        endcase
        pc++;
    end
endfunction

`endif

/* tests/tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core;

    localparam int num_programs = 24;
    localparam int limit_cycles = num_programs * (64 * 5 + 200);

    logic                           clk = 1'b0;
    logic                           rst_n = 1'b0;
    logic                           start = 1'b0;
    core_pkg::host_cmd_t            host = '0;
    logic                           busy;
    logic                           done;
    logic [core_pkg::glb_width-1:0] glb_rdata;
    integer                         seed = 32'h61f71942;
    int                             cycle_cnt = 0;
    int                             data_errors = 0;
    int                             ctrl_errors = 0;
    int                             done_count = 0;
    logic                           busy_prev = 1'b0;
    logic                           done_prev = 1'b0;
    int                             due_q [$];
    logic [core_pkg::glb_width-1:0] exp_q [$];
    logic [core_pkg::isa_width-1:0] prog [core_pkg::isa_words];
    logic [core_pkg::glb_width-1:0] word_a;
    logic [core_pkg::glb_width-1:0] word_b;
    logic [core_pkg::glb_width-1:0] word_x;
    int                             len;

    `include "tb_model.svh"

    core_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .host      (host),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .glb_rdata (glb_rdata)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare_word(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            data_errors++;
        end
    endtask

    task automatic compare_level(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
            ctrl_errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("Error at t=%0t: %s", $time, what);
            ctrl_errors++;
        end
    endtask

    task automatic buffer_write(input int addr, input logic [127:0] data);
        host.glb_we   = 1'b1;
        host.addr     = addr[5:0];
        host.wdata    = data;
        exp_glb[addr] = data;
        @(negedge clk);
        host.glb_we = 1'b0;
    endtask

    task automatic instr_write(input int addr, input logic [31:0] data);
        host.isa_we   = 1'b1;
        host.addr     = addr[5:0];
        host.wdata    = {96'h0, data};
        exp_isa[addr] = data;
        @(negedge clk);
        host.isa_we = 1'b0;
    endtask

    // Queues the expected word for the cycle after the read and for each hold cycle
    task automatic buffer_read(input int addr, input logic [127:0] exp, input int hold);
        host.glb_re = 1'b1;
        host.addr   = addr[5:0];
        due_q.push_back(cycle_cnt + 1);
        exp_q.push_back(exp);
        @(negedge clk);
        host.glb_re = 1'b0;
        for (int i = 1; i <= hold; i++) begin
            due_q.push_back(cycle_cnt + i);
            exp_q.push_back(exp);
        end
        repeat (hold) @(negedge clk);
    endtask

    task automatic fill_buffer();
        for (int a = 0; a < core_pkg::glb_words; a++) begin
            buffer_write(a, {$random(seed), $random(seed), $random(seed), $random(seed)});
        end
    endtask

    task automatic verify_buffer();
        for (int a = 0; a < core_pkg::glb_words; a++) begin
            buffer_read(a, exp_glb[a], 0);
        end
    endtask

    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        word = $random(seed);  // Reserved bits stay random
        case ({$random(seed)} % 3)
            0: word[31:28] = core_pkg::op_set;
            1: word[31:28] = core_pkg::op_load;
            default: word[31:28] = core_pkg::op_store;
        endcase
        return word;
    endfunction

    task automatic run_program(input int n, input bit noise);
        for (int i = 0; i < n; i++) begin
            instr_write(i, prog[i]);
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_level("busy", 1'b1, busy);
        if (noise) begin
            host.glb_re = 1'b1;  // Must not reach the buffer while busy
            host.addr   = 6'd9;
            repeat (4) @(negedge clk);
            host.glb_re = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
        run_model();
        @(negedge clk);
    endtask

    always @(negedge clk) begin : compare_outputs
        logic [127:0] exp_word;
        if (rst_n) begin
            while (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
                due_q.delete(0);
                exp_word = exp_q.pop_front();
                compare_word("glb_rdata", exp_word, glb_rdata);
            end
            if (done) begin
                require(!done_prev, "done stayed high for more than one cycle");
                require(!busy, "busy was still high while done was high");
                done_count++;
            end
            if (busy_prev && !busy) begin
                require(done, "busy fell without a done pulse");
            end
            busy_prev = busy;
            done_prev = done;
        end
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_level("busy", 1'b0, busy);
        compare_level("done", 1'b0, done);
        compare_word("glb_rdata", '0, glb_rdata);

        fill_buffer();
        for (int a = 0; a < core_pkg::glb_words; a++) begin
            buffer_read(a, exp_glb[a], 3);
        end

        prog[0] = {core_pkg::op_set, 20'h0, 8'ha5};
        prog[1] = {core_pkg::op_store, 22'h0, 6'd10};
        prog[2] = 32'h0;
        run_program(3, 1'b0);
        buffer_read(10, {16{8'ha5}}, 0);

        // Every lane overflows when the three values are added
        for (int i = 0; i < core_pkg::lanes; i++) begin
            word_a[i*8 +: 8] = 'h90 + 3 * i;
            word_b[i*8 +: 8] = 'ha0 + 5 * i;
            word_x[i*8 +: 8] = ('h40 + 'h90 + 3 * i + 'ha0 + 5 * i) % 256;
        end
        buffer_write(20, word_a);
        buffer_write(21, word_b);
        prog[0] = {core_pkg::op_set, 20'h0, 8'h40};
        prog[1] = {core_pkg::op_load, 22'h0, 6'd20};
        prog[2] = {core_pkg::op_load, 22'h0, 6'd21};
        prog[3] = {core_pkg::op_store, 22'h0, 6'd22};
        prog[4] = 32'h0;
        run_program(5, 1'b0);
        buffer_read(22, word_x, 0);

        buffer_read(7, exp_glb[7], 0);
        prog[0] = {core_pkg::op_set, 20'h0, 8'h3c};
        prog[1] = {core_pkg::op_store, 22'h0, 6'd5};
        prog[2] = 32'h0;
        run_program(3, 1'b1);
        compare_word("glb_rdata", exp_glb[7], glb_rdata);  // Still the word read before start
        buffer_read(5, {16{8'h3c}}, 0);

        repeat (20) begin
            fill_buffer();
            len = 1 + ({$random(seed)} % 12);
            for (int i = 0; i < len - 1; i++) begin
                prog[i] = random_instr();
            end
            prog[len - 1] = 32'h0;
            run_program(len, 1'b0);
            verify_buffer();
        end

        for (int i = 0; i < core_pkg::isa_words; i++) begin
            prog[i] = random_instr();
        end
        run_program(core_pkg::isa_words, 1'b0);
        verify_buffer();

        repeat (3) @(negedge clk);
        require(due_q.size() == 0, "some read checks were never performed");
        require(done_count == num_programs, "done pulse count does not match the run count");
        $display("Errors: %0d data, %0d control", data_errors, ctrl_errors);
        if (data_errors == 0 && ctrl_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+tests
verilog/core_pkg.sv
verilog/sram_bank.sv
verilog/vec_acc.sv
verilog/core_ctrl.sv
verilog/core_top.sv
tests/tb_core.sv
